// File: agc_ctrl_top.f
rtl/agc_data_pkg.sv
rtl/agc_ctrl_pkg.sv
rtl/agc_host_regs.sv
rtl/agc_loop_fsm.sv
rtl/agc_gain_calc.sv
rtl/agc_sample_unit.sv
rtl/agc_ctrl_top.sv
tb/agc_ctrl_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the AGC testbench with Verilator and run it; exit status is the result
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module agc_ctrl_tb \
    -f agc_ctrl_top.f -o agc_ctrl_sim &&
./obj_dir/agc_ctrl_sim ||
exit 1

// File: tb/agc_ctrl_tb.sv
`timescale 1ns/10ps

module agc_ctrl_tb;
    import agc_ctrl_pkg::*;
    import agc_data_pkg::*;

    localparam int          CLK_PERIOD      = 20;
    localparam int          RESET_CYCLES    = 5;
    localparam logic [31:0] SEED            = 32'hf79c_b50d;
    localparam int          WIN_LOG2        = 6;
    localparam int          WINDOW_LEN      = 1 << WIN_LOG2;
    localparam int          FRAC_BITS       = 10;
    localparam int          SCALE_STEP_INIT = 30;
    localparam int          OFFSET_STEP_INIT = 1;
    localparam int          OFFSET_STEP     = 1;
    localparam int          ACK_LIMIT       = 16;     // Ack is due three edges after the request
    localparam logic [7:0]  ADR_SCALE_STEP  = 8'h40;
    localparam logic [7:0]  ADR_OFFSET_STEP = 8'h44;

    ////////////////////
    // Run length

    localparam int READ_GAP   = 40;    // Well below one loop iteration
    localparam int P3_READS   = 80;
    localparam int P4_WAIT    = 300;   // Two iterations flush the old windows
    localparam int P4_READS   = 14;
    localparam int HOST_OP    = 4;     // Cycles per host access
    localparam int RUN_CYCLES = 200 + P3_READS * (READ_GAP + HOST_OP) + P4_WAIT +
                                P4_READS * (READ_GAP + 4 * HOST_OP);
    localparam int MAX_CYCLES = 4 * RUN_CYCLES;

    logic        aclk;
    logic        wb_rst_i;
    sample_t     dat_i;
    out_t        dat_o;
    logic        host_cyc_i;
    logic        host_stb_i;
    logic        host_we_i;
    logic [7:0]  host_adr_i;
    logic [31:0] host_dat_i;
    logic [31:0] host_dat_o;
    logic        host_ack_o;
    sample_t     prev_sample;    // Sample that dat_o currently reflects
    int          stim_kind;      // 0 full range, 1 large balanced, 2 small positive
    int          cycle_cnt;

    agc_ctrl_top #(
        .WINDOW_LOG2        (WIN_LOG2),
        .START_SCALE_DELTA  (SCALE_STEP_INIT),
        .START_OFFSET_DELTA (OFFSET_STEP_INIT)
    ) DUT (
        .aclk       (aclk),
        .wb_rst_i   (wb_rst_i),
        .dat_i      (dat_i),
        .dat_o      (dat_o),
        .host_cyc_i (host_cyc_i),
        .host_stb_i (host_stb_i),
        .host_we_i  (host_we_i),
        .host_adr_i (host_adr_i),
        .host_dat_i (host_dat_i),
        .host_dat_o (host_dat_o),
        .host_ack_o (host_ack_o)
    );

    initial begin
        aclk = 1'b0;
        forever #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    ////////////////////
    // Helpers

    function automatic logic [31:0] lcg_step(input logic [31:0] x);
        return x * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic sample_t make_sample(input int kind, input logic [31:0] r);
        logic signed [11:0] big;
        big = 12'sd1024 + $signed({2'b00, r[25:16]});
        if (kind == 1) begin
            return r[31] ? -big : big;   // Sign is a coin toss
        end
        if (kind == 2) begin
            return 12'sd56 + $signed({9'd0, r[31:29]});
        end
        if (r[31:29] == 3'd0) begin
            return 12'sh7ff;
        end
        if (r[31:29] == 3'd1) begin
            return 12'sh800;
        end
        return sample_t'(r[27:16]);
    endfunction

    // Scale, shift, offset and clip to the 5 bit output range
    function automatic out_t expected_out(input sample_t s, input longint scale,
                                          input longint offset);
        longint v;
        v = (longint'(s) * scale) >>> FRAC_BITS;
        v = v + offset;
        if (v > 15) begin
            return 5'b01111;
        end
        if (v < -16) begin
            return 5'b10000;
        end
        return out_t'(v);
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    task automatic host_access(input logic we, input logic [7:0] adr,
                               input logic [31:0] wdat, output logic [31:0] rdat);
        int waited;
        @(posedge aclk);
        host_cyc_i <= 1'b1;
        host_stb_i <= 1'b1;
        host_we_i  <= we;
        host_adr_i <= adr;
        host_dat_i <= wdat;
        waited = 0;
        do begin
            @(negedge aclk);
            waited++;
            if (waited > ACK_LIMIT) begin
                fail_run("Host acknowledge never arrived");
            end
        end while (!host_ack_o);
        rdat = host_dat_o;
        @(posedge aclk);
        host_cyc_i <= 1'b0;
        host_stb_i <= 1'b0;
        host_we_i  <= 1'b0;
    endtask

    task automatic host_write(input logic [7:0] adr, input logic [31:0] wdat);
        logic [31:0] unused;
        host_access(1'b1, adr, wdat, unused);
    endtask

    task automatic host_read(input logic [7:0] adr, output logic [31:0] rdat);
        host_access(1'b0, adr, 32'd0, rdat);
    endtask

    // Sample stream, one new sample per clock
    initial begin
        logic [31:0] sample_seed;
        sample_seed = SEED;
        dat_i       = '0;
        prev_sample = '0;
        forever begin
            @(posedge aclk);
            sample_seed = lcg_step(sample_seed);
            prev_sample <= dat_i;
            dat_i       <= make_sample(stim_kind, sample_seed);
        end
    end

    initial begin
        cycle_cnt = 0;
        forever begin
            @(posedge aclk);
            cycle_cnt++;
            if (cycle_cnt >= MAX_CYCLES) begin
                fail_run("Run exceeded its cycle limit");
            end
        end
    end

    ////////////////////
    // Test sequence

    initial begin
        logic [31:0] host_seed;
        logic [31:0] rd;
        logic [31:0] wd_scale;
        logic [31:0] wd_offset;
        logic [31:0] scale_step;
        logic [31:0] prev_scale;
        logic [31:0] prev_offset;
        logic [31:0] first_offset;
        logic [31:0] gt;
        logic [31:0] lt;
        logic [31:0] status;
        logic        saw_hi;
        logic        saw_lo;

        host_seed  = SEED;
        stim_kind  = 0;
        saw_hi     = 1'b0;
        saw_lo     = 1'b0;
        wb_rst_i   = 1'b1;
        host_cyc_i = 1'b0;
        host_stb_i = 1'b0;
        host_we_i  = 1'b0;
        host_adr_i = '0;
        host_dat_i = '0;
        repeat (RESET_CYCLES) @(posedge aclk);
        wb_rst_i <= 1'b0;
        @(posedge aclk);

        // Unity gain holds until the boot write-back
        for (int i = 0; i < 30; i++) begin
            @(negedge aclk);
            check_value("dat_o", 32'(dat_o), 32'(expected_out(prev_sample, START_SCALE, 0)));
            if (dat_o == 5'b01111) begin
                saw_hi = 1'b1;
            end
            if (dat_o == 5'b10000) begin
                saw_lo = 1'b1;
            end
        end
        if (!saw_hi || !saw_lo) begin
            fail_run("Output never reached both saturation limits");
        end
        stim_kind = 1;

        host_read(ADR_SCALE_STEP, rd);
        check_value("scale_delta", rd, 32'(SCALE_STEP_INIT));
        host_read(ADR_OFFSET_STEP, rd);
        check_value("offset_delta", rd, 32'(OFFSET_STEP_INIT));
        for (int i = 0; i < 3; i++) begin
            host_seed     = lcg_step(host_seed);
            wd_scale      = host_seed;
            host_seed     = lcg_step(host_seed);
            wd_offset     = host_seed;
            wd_offset[15] = i[0];        // Both signs of the offset
            host_write(ADR_SCALE_STEP, wd_scale);
            host_write(ADR_OFFSET_STEP, wd_offset);
            host_read(ADR_SCALE_STEP, rd);
            check_value("scale_delta", rd, {15'd0, wd_scale[16:0]});
            host_read(ADR_OFFSET_STEP, rd);
            check_value("offset_delta", rd, {{16{wd_offset[15]}}, wd_offset[15:0]});
        end

        // Steps land before the first window ends, so no calculation sees the random ones
        host_seed  = lcg_step(host_seed);
        scale_step = 32'd40 + {28'd0, host_seed[31:28]};
        host_write(ADR_SCALE_STEP, scale_step);
        host_write(ADR_OFFSET_STEP, 32'd0);

        // Large input, the gain may only walk down
        host_read(8'(INFO_SCALE * 4), prev_scale);
        for (int i = 0; i < P3_READS; i++) begin
            repeat (READ_GAP) @(posedge aclk);
            host_read(8'(INFO_SCALE * 4), rd);
            if (rd != prev_scale) begin
                check_value("INFO_SCALE", rd, prev_scale - scale_step);
            end
            if (rd < 32'(SCALE_MIN) - scale_step) begin
                fail_run("Scale went below the lower gain limit");
            end
            prev_scale = rd;
        end
        if (prev_scale >= 32'(START_SCALE)) begin
            fail_run("Scale never dropped under large input");
        end

        @(negedge aclk);
        stim_kind = 2;
        host_write(ADR_OFFSET_STEP, 32'(OFFSET_STEP));
        repeat (P4_WAIT) @(posedge aclk);
        host_read(8'(INFO_OFFSET * 4), prev_offset);
        first_offset = prev_offset;
        for (int i = 0; i < P4_READS; i++) begin
            repeat (READ_GAP) @(posedge aclk);
            host_read(8'(INFO_STATUS * 4), status);
            host_read(8'(INFO_GT * 4), gt);
            host_read(8'(INFO_LT * 4), lt);
            if (status[STATUS_DONE] && gt + lt > 32'(WINDOW_LEN)) begin
                fail_run("Sign counts add up to more than one window");
            end
            if (gt <= lt) begin
                fail_run("Count above zero does not exceed count below zero");
            end
            host_read(8'(INFO_OFFSET * 4), rd);
            if (rd != prev_offset) begin
                check_value("INFO_OFFSET", rd, prev_offset - 32'(OFFSET_STEP));
            end
            prev_offset = rd;
        end
        if (prev_offset == first_offset) begin
            fail_run("Offset never moved under positive input");
        end

        $display("All checks passed");
        $finish;
    end

endmodule

// File: rtl/agc_ctrl_top.sv
`timescale 1ns/10ps

module agc_ctrl_top #(
    parameter int WINDOW_LOG2        = 6,
    parameter int TARGET_MEAN_SQ     = 16,
    parameter int SCALE_ERR          = 2,
    parameter int OFFSET_ERR         = 5,
    parameter int START_SCALE_DELTA  = 30,
    parameter int START_OFFSET_DELTA = 1
) (
    input  logic                  aclk,
    input  logic                  wb_rst_i,
    input  agc_data_pkg::sample_t dat_i,
    output agc_data_pkg::out_t    dat_o,
    input  logic                  host_cyc_i,
    input  logic                  host_stb_i,
    input  logic                  host_we_i,
    input  logic [7:0]            host_adr_i,
    input  logic [31:0]           host_dat_i,
    output logic [31:0]           host_dat_o,
    output logic                  host_ack_o
);
    import agc_data_pkg::*;
    import agc_ctrl_pkg::*;

    // Internal link, loop FSM to sample unit
    logic                     unit_cyc;
    logic                     unit_we;
    logic [7:0]               unit_adr;
    logic [31:0]              unit_wdat;
    logic                     unit_ack;
    logic [31:0]              unit_rdat;

    stat_t [N_INFO-1:0]       info;
    scale_t                   new_scale;
    offset_t                  new_offset;
    logic                     calc_en;
    scale_t                   scale_delta;
    offset_t                  offset_delta;

    agc_host_regs #(
        .START_SCALE_DELTA  (START_SCALE_DELTA),
        .START_OFFSET_DELTA (START_OFFSET_DELTA)
    ) u_host_regs (
        .aclk           (aclk),
        .wb_rst_i       (wb_rst_i),
        .host_cyc_i     (host_cyc_i),
        .host_stb_i     (host_stb_i),
        .host_we_i      (host_we_i),
        .host_adr_i     (host_adr_i),
        .host_dat_i     (host_dat_i),
        .host_dat_o     (host_dat_o),
        .host_ack_o     (host_ack_o),
        .info_i         (info),
        .scale_delta_o  (scale_delta),
        .offset_delta_o (offset_delta)
    );

    agc_loop_fsm u_loop_fsm (
        .aclk         (aclk),
        .wb_rst_i     (wb_rst_i),
        .unit_cyc_o   (unit_cyc),
        .unit_we_o    (unit_we),
        .unit_adr_o   (unit_adr),
        .unit_wdat_o  (unit_wdat),
        .unit_ack_i   (unit_ack),
        .unit_rdat_i  (unit_rdat),
        .info_o       (info),
        .new_scale_i  (new_scale),
        .new_offset_i (new_offset),
        .calc_en_o    (calc_en)
    );

    agc_gain_calc #(
        .WINDOW_LOG2    (WINDOW_LOG2),
        .TARGET_MEAN_SQ (TARGET_MEAN_SQ),
        .SCALE_ERR      (SCALE_ERR),
        .OFFSET_ERR     (OFFSET_ERR)
    ) u_gain_calc (
        .aclk           (aclk),
        .wb_rst_i       (wb_rst_i),
        .calc_en_i      (calc_en),
        .info_i         (info),
        .scale_delta_i  (scale_delta),
        .offset_delta_i (offset_delta),
        .new_scale_o    (new_scale),
        .new_offset_o   (new_offset)
    );

    agc_sample_unit #(
        .WINDOW_LOG2 (WINDOW_LOG2)
    ) u_sample_unit (
        .aclk        (aclk),
        .wb_rst_i    (wb_rst_i),
        .dat_i       (dat_i),
        .dat_o       (dat_o),
        .unit_cyc_i  (unit_cyc),
        .unit_we_i   (unit_we),
        .unit_adr_i  (unit_adr),
        .unit_wdat_i (unit_wdat),
        .unit_ack_o  (unit_ack),
        .unit_rdat_o (unit_rdat)
    );

endmodule

// File: rtl/agc_sample_unit.sv
`timescale 1ns/10ps

module agc_sample_unit #(
    parameter int WINDOW_LOG2 = 6
) (
    input  logic                  aclk,
    input  logic                  wb_rst_i,
    input  agc_data_pkg::sample_t dat_i,
    output agc_data_pkg::out_t    dat_o,
    input  logic                  unit_cyc_i,
    input  logic                  unit_we_i,
    input  logic [7:0]            unit_adr_i,
    input  logic [31:0]           unit_wdat_i,
    output logic                  unit_ack_o,
    output logic [31:0]           unit_rdat_o
);
    import agc_data_pkg::*;
    import agc_ctrl_pkg::*;

    scale_t                 pending_scale;
    scale_t                 staged_scale;
    scale_t                 active_scale;
    offset_t                pending_offset;
    offset_t                staged_offset;
    offset_t                active_offset;
    logic signed [30:0]     prod;
    logic signed [31:0]     scaled;
    out_t                   sat;
    logic signed [9:0]      sq;
    stat_t                  sum_sq;
    stat_t                  gt_cnt;
    stat_t                  lt_cnt;
    stat_t                  status;
    logic [WINDOW_LOG2-1:0] win_cnt;
    logic                   running;
    logic                   done;
    logic                   req;
    logic                   wr;
    logic                   cmd_start;
    logic                   cmd_reset;
    logic                   cmd_load;
    logic                   cmd_apply;

    ////////////////////
    // Data path

    assign prod   = dat_i * $signed({1'b0, active_scale});
    assign scaled = (prod >>> SCALE_FRAC_BITS) + active_offset;
    assign sq     = sat * sat;

    always_comb begin
        if (scaled > 32'sd15) begin
            sat = 5'b01111;
        end else if (scaled < -32'sd16) begin
            sat = 5'b10000;
        end else begin
            sat = out_t'(scaled);
        end
    end

    ////////////////////
    // Command target

    assign req       = unit_cyc_i && !unit_ack_o;   // Each request is seen once
    assign wr        = req && unit_we_i;
    assign cmd_start = wr && unit_adr_i == ADDR_CTRL && |(unit_wdat_i & CMD_START);
    assign cmd_reset = wr && unit_adr_i == ADDR_CTRL && |(unit_wdat_i & CMD_RESET);
    assign cmd_load  = wr && unit_adr_i == ADDR_CTRL && |(unit_wdat_i & CMD_LOAD);
    assign cmd_apply = wr && unit_adr_i == ADDR_CTRL && |(unit_wdat_i & CMD_APPLY);

    always_comb begin
        status              = '0;
        status[STATUS_BUSY] = running;
        status[STATUS_DONE] = done;
    end

    always_ff @(posedge aclk) begin
        if (wb_rst_i) begin
            dat_o          <= '0;
            unit_ack_o     <= 1'b0;
            sum_sq         <= '0;
            gt_cnt         <= '0;
            lt_cnt         <= '0;
            win_cnt        <= '0;
            running        <= 1'b0;
            done           <= 1'b0;
            pending_scale  <= scale_t'(START_SCALE);
            staged_scale   <= scale_t'(START_SCALE);
            active_scale   <= scale_t'(START_SCALE);
            pending_offset <= offset_t'(START_OFFSET);
            staged_offset  <= offset_t'(START_OFFSET);
            active_offset  <= offset_t'(START_OFFSET);
        end else begin
            dat_o      <= sat;
            unit_ack_o <= req;
            if (running) begin
                sum_sq  <= sum_sq + stat_t'(sq);
                win_cnt <= win_cnt + 1'b1;
                if (sat > 0) begin
                    gt_cnt <= gt_cnt + 1'b1;
                end
                if (sat < 0) begin
                    lt_cnt <= lt_cnt + 1'b1;
                end
                if (&win_cnt) begin   // Last sample of the window
                    running <= 1'b0;
                    done    <= 1'b1;
                end
            end
            // Commands come last so they win over the window update
            if (cmd_start || cmd_reset) begin
                sum_sq  <= '0;
                gt_cnt  <= '0;
                lt_cnt  <= '0;
                win_cnt <= '0;
                done    <= 1'b0;
                running <= cmd_start;
            end
            if (cmd_load) begin
                staged_scale  <= pending_scale;
                staged_offset <= pending_offset;
            end
            if (cmd_apply) begin
                active_scale  <= staged_scale;
                active_offset <= staged_offset;
            end
            if (wr && unit_adr_i == ADDR_SCALE) begin
                pending_scale <= scale_t'(unit_wdat_i);
            end
            if (wr && unit_adr_i == ADDR_OFFSET) begin
                pending_offset <= offset_t'(unit_wdat_i);
            end
        end
    end

    // Read data valid with the acknowledge
    always_ff @(posedge aclk) begin
        if (req) begin
            case (unit_adr_i[4:2])
                3'(INFO_STATUS): unit_rdat_o <= status;
                3'(INFO_SUM_SQ): unit_rdat_o <= sum_sq;
                3'(INFO_GT):     unit_rdat_o <= gt_cnt;
                3'(INFO_LT):     unit_rdat_o <= lt_cnt;
                3'(INFO_SCALE):  unit_rdat_o <= stat_t'(active_scale);
                3'(INFO_OFFSET): unit_rdat_o <= stat_t'(active_offset);
                default:         unit_rdat_o <= '0;
            endcase
        end
    end

endmodule

// File: rtl/agc_gain_calc.sv
`timescale 1ns/10ps

module agc_gain_calc #(
    parameter int WINDOW_LOG2    = 6,
    parameter int TARGET_MEAN_SQ = 16,
    parameter int SCALE_ERR      = 2,
    parameter int OFFSET_ERR     = 5
) (
    input  logic                                          aclk,
    input  logic                                          wb_rst_i,
    input  logic                                          calc_en_i,
    input  agc_data_pkg::stat_t [agc_ctrl_pkg::N_INFO-1:0] info_i,
    input  agc_data_pkg::scale_t                          scale_delta_i,
    input  agc_data_pkg::offset_t                         offset_delta_i,
    output agc_data_pkg::scale_t                          new_scale_o,
    output agc_data_pkg::offset_t                         new_offset_o
);
    import agc_data_pkg::*;
    import agc_ctrl_pkg::*;

    stat_t   mean_sq;
    scale_t  cur_scale;
    offset_t cur_offset;

    assign mean_sq    = info_i[INFO_SUM_SQ] >> WINDOW_LOG2;   // Per sample
    assign cur_scale  = scale_t'(info_i[INFO_SCALE]);
    assign cur_offset = offset_t'(info_i[INFO_OFFSET]);

    always_ff @(posedge aclk) begin
        if (wb_rst_i) begin
            new_scale_o  <= scale_t'(START_SCALE);
            new_offset_o <= offset_t'(START_OFFSET);
        end else if (calc_en_i) begin
            // Fixed steps toward the target power, inside the gain limits
            if (mean_sq > stat_t'(TARGET_MEAN_SQ + SCALE_ERR) &&
                cur_scale > scale_t'(SCALE_MIN)) begin
                new_scale_o <= cur_scale - scale_delta_i;
            end else if (mean_sq < stat_t'(TARGET_MEAN_SQ - SCALE_ERR) &&
                         cur_scale < scale_t'(SCALE_MAX)) begin
                new_scale_o <= cur_scale + scale_delta_i;
            end else begin
                new_scale_o <= cur_scale;
            end

            // Pull the baseline toward an even sign balance
            if (info_i[INFO_GT] > info_i[INFO_LT] + stat_t'(OFFSET_ERR)) begin
                new_offset_o <= cur_offset - offset_delta_i;
            end else if (info_i[INFO_LT] > info_i[INFO_GT] + stat_t'(OFFSET_ERR)) begin
                new_offset_o <= cur_offset + offset_delta_i;
            end else begin
                new_offset_o <= cur_offset;
            end
        end
    end

endmodule

// File: rtl/agc_loop_fsm.sv
`timescale 1ns/10ps

module agc_loop_fsm (
    input  logic                                          aclk,
    input  logic                                          wb_rst_i,
    output logic                                          unit_cyc_o,
    output logic                                          unit_we_o,
    output logic [7:0]                                    unit_adr_o,
    output logic [31:0]                                   unit_wdat_o,
    input  logic                                          unit_ack_i,
    input  logic [31:0]                                   unit_rdat_i,
    output agc_data_pkg::stat_t [agc_ctrl_pkg::N_INFO-1:0] info_o,
    input  agc_data_pkg::scale_t                          new_scale_i,
    input  agc_data_pkg::offset_t                         new_offset_i,
    output logic                                          calc_en_o
);
    import agc_data_pkg::*;
    import agc_ctrl_pkg::*;

    loop_state_t loop_state;
    bus_state_t  bus_state;
    logic [2:0]  idx;          // Info word, write slot or calc cycle
    logic [4:0]  boot_cnt;
    stat_t       resp;         // Last read response
    logic        req_we;
    logic [7:0]  req_adr;
    stat_t       req_wdat;

    // Gain calc samples the info copy on the first CALCULATING cycle
    assign calc_en_o = (loop_state == CALCULATING) && (idx == '0);

    ////////////////////
    // Request per state

    always_comb begin
        req_we   = 1'b1;
        req_adr  = ADDR_CTRL;
        req_wdat = '0;
        case (loop_state)
            RESETTING: req_wdat = CMD_RESET;
            POLLING:   req_wdat = CMD_START;
            WAITING:   req_we   = 1'b0;      // Status word
            READING: begin
                req_we  = 1'b0;
                req_adr = {3'b000, idx, 2'b00};
            end
            WRITING: begin
                if (idx == '0) begin
                    req_adr  = ADDR_SCALE;
                    req_wdat = stat_t'(new_scale_i);
                end else begin
                    req_adr  = ADDR_OFFSET;
                    req_wdat = stat_t'(new_offset_i);
                end
            end
            LOADING:  req_wdat = CMD_LOAD;
            APPLYING: req_wdat = CMD_APPLY;
            default: ;
        endcase
    end

    ////////////////////
    // Loop and master

    always_ff @(posedge aclk) begin
        if (wb_rst_i) begin
            loop_state         <= BOOT_DELAY;
            bus_state          <= BUS_SENDING;
            idx                <= '0;
            boot_cnt           <= 5'(BOOT_CYCLES);
            unit_cyc_o         <= 1'b0;
            info_o             <= '0;
            info_o[INFO_SCALE] <= stat_t'(START_SCALE);
        end else if (loop_state == BOOT_DELAY) begin
            if (boot_cnt != '0) begin
                boot_cnt <= boot_cnt - 1'b1;
            end else begin
                loop_state <= WRITING;   // Push the start values first
            end
        end else if (loop_state == CALCULATING) begin
            if (idx == '0) begin
                idx <= 3'd1;
            end else begin
                loop_state <= WRITING;   // New values registered by now
                idx        <= '0;
            end
        end else begin
            case (bus_state)
                BUS_SENDING: begin
                    unit_cyc_o  <= 1'b1;
                    unit_we_o   <= req_we;
                    unit_adr_o  <= req_adr;
                    unit_wdat_o <= req_wdat;
                    bus_state   <= BUS_WAITING;
                end
                BUS_WAITING: begin
                    if (unit_ack_i) begin
                        unit_cyc_o <= 1'b0;
                        resp       <= unit_rdat_i;
                        bus_state  <= BUS_PROCESSING;
                    end
                end
                default: begin
                    bus_state <= BUS_SENDING;
                    case (loop_state)
                        RESETTING: loop_state <= POLLING;
                        POLLING:   loop_state <= WAITING;
                        WAITING: begin
                            if (resp[STATUS_DONE]) begin
                                loop_state <= READING;
                            end
                        end
                        READING: begin
                            info_o[idx] <= resp;
                            if (idx == 3'(N_INFO - 1)) begin
                                loop_state <= CALCULATING;
                                idx        <= '0;
                            end else begin
                                idx <= idx + 1'b1;
                            end
                        end
                        WRITING: begin
                            if (idx == '0) begin
                                idx <= 3'd1;           // Offset next
                            end else begin
                                loop_state <= LOADING;
                                idx        <= '0;
                            end
                        end
                        LOADING: loop_state <= APPLYING;
                        default: begin
                            // APPLY acknowledged, the unit now runs these
                            loop_state          <= RESETTING;
                            info_o[INFO_SCALE]  <= stat_t'(new_scale_i);
                            info_o[INFO_OFFSET] <= stat_t'(new_offset_i);
                        end
                    endcase
                end
            endcase
        end
    end

endmodule

// File: rtl/agc_host_regs.sv
`timescale 1ns/10ps

module agc_host_regs #(
    parameter int START_SCALE_DELTA  = 30,
    parameter int START_OFFSET_DELTA = 1
) (
    input  logic                                          aclk,
    input  logic                                          wb_rst_i,
    input  logic                                          host_cyc_i,
    input  logic                                          host_stb_i,
    input  logic                                          host_we_i,
    input  logic [7:0]                                    host_adr_i,
    input  logic [31:0]                                   host_dat_i,
    output logic [31:0]                                   host_dat_o,
    output logic                                          host_ack_o,
    input  agc_data_pkg::stat_t [agc_ctrl_pkg::N_INFO-1:0] info_i,
    output agc_data_pkg::scale_t                          scale_delta_o,
    output agc_data_pkg::offset_t                         offset_delta_o
);
    import agc_data_pkg::*;
    import agc_ctrl_pkg::*;

    host_state_t state;

    assign host_ack_o = (state == ACK);   // One cycle wide

    always_ff @(posedge aclk) begin
        if (wb_rst_i) begin
            state          <= IDLE;
            scale_delta_o  <= scale_t'(START_SCALE_DELTA);
            offset_delta_o <= offset_t'(START_OFFSET_DELTA);
        end else begin
            case (state)
                IDLE: begin
                    if (host_cyc_i && host_stb_i) begin
                        state <= host_we_i ? WRITE : READ;
                    end
                end
                WRITE, READ: state <= ACK;
                default:     state <= IDLE;
            endcase

            // Bit 6 selects the loop's own step registers
            if (state == WRITE && host_adr_i[6]) begin
                if (host_adr_i[5:2] == 4'd0) begin
                    scale_delta_o <= scale_t'(host_dat_i);
                end else if (host_adr_i[5:2] == 4'd1) begin
                    offset_delta_o <= offset_t'(host_dat_i);
                end
            end
        end
    end

    ////////////////////
    // Read response

    always_ff @(posedge aclk) begin
        if (state == READ) begin
            if (host_adr_i[6]) begin
                case (host_adr_i[5:2])
                    4'd0:    host_dat_o <= stat_t'(scale_delta_o);
                    4'd1:    host_dat_o <= stat_t'(offset_delta_o);   // Sign extended
                    default: host_dat_o <= '0;
                endcase
            end else if (host_adr_i[4:2] < 3'(N_INFO)) begin
                host_dat_o <= info_i[host_adr_i[4:2]];   // Last copy from the unit
            end else begin
                host_dat_o <= '0;
            end
        end
    end

endmodule

// File: rtl/agc_ctrl_pkg.sv
package agc_ctrl_pkg;

    ////////////////////
    // FSM encodings

    typedef enum logic [3:0] {
        BOOT_DELAY,
        RESETTING,
        POLLING,        // Start a sample window
        WAITING,        // Poll status until done
        READING,
        CALCULATING,
        WRITING,
        LOADING,
        APPLYING
    } loop_state_t;

    // One transaction on the internal link
    typedef enum logic [1:0] {
        BUS_SENDING,
        BUS_WAITING,
        BUS_PROCESSING
    } bus_state_t;

    typedef enum logic [1:0] {
        IDLE,
        WRITE,
        READ,
        ACK
    } host_state_t;

    ////////////////////
    // Sample unit map

    // Control word bits, LOAD and APPLY may be combined
    typedef enum logic [31:0] {
        CMD_START = 32'h0000_0001,
        CMD_RESET = 32'h0000_0004,
        CMD_LOAD  = 32'h0000_0100,
        CMD_APPLY = 32'h0000_0200
    } agc_cmd_t;

    localparam int INFO_STATUS = 0;
    localparam int INFO_SUM_SQ = 1;
    localparam int INFO_GT     = 2;
    localparam int INFO_LT     = 3;
    localparam int INFO_SCALE  = 4;
    localparam int INFO_OFFSET = 5;
    localparam int N_INFO      = 6;

    localparam int STATUS_BUSY = 0;   // Window running
    localparam int STATUS_DONE = 1;

    localparam logic [7:0] ADDR_CTRL   = 8'h00;
    localparam logic [7:0] ADDR_SCALE  = 8'h10;
    localparam logic [7:0] ADDR_OFFSET = 8'h14;

    localparam int START_SCALE  = 1024;      // Unity gain
    localparam int START_OFFSET = 0;
    localparam int SCALE_MIN    = 300;
    localparam int SCALE_MAX    = 'h1FBD0;
    localparam int BOOT_CYCLES  = 31;

endpackage

// File: rtl/agc_data_pkg.sv
package agc_data_pkg;

    // Raw ADC sample in
    typedef logic signed [11:0] sample_t;

    // Saturated trigger sample out
    typedef logic signed [4:0] out_t;

    // Gain, 7 integer bits and 10 fraction bits
    typedef logic [16:0] scale_t;

    // Offset in output steps
    typedef logic signed [15:0] offset_t;

    // One info or statistic word
    typedef logic [31:0] stat_t;

    localparam int SCALE_FRAC_BITS = 10;

endpackage
